// File: Makefile
# Verilator flow for the Gauss-Seidel solver testbench
TOP := gs_solver_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: flist.f
hdl/gs_num_pkg.sv
hdl/gs_bus_pkg.sv
hdl/gs_regs.sv
hdl/gs_sequencer.sv
hdl/gs_row_engine.sv
hdl/gs_solver_top.sv
tests/gs_result_checker.sv
tests/gs_solver_tb.sv

// File: hdl/gs_bus_pkg.sv
`default_nettype none

package gs_bus_pkg;

	typedef logic [9:0] mem_addr_t; // matrix memory word address
	typedef logic [4:0] sweep_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	localparam logic [3:0] REG_CTRL = 4'd0; // bit 0 start
	localparam logic [3:0] REG_BASE = 4'd1;
	localparam logic [3:0] REG_SWEEPS = 4'd2;
	localparam logic [3:0] REG_STATUS = 4'd3; // {done, busy}

	typedef struct packed {
		mem_addr_t base;
		sweep_t    sweeps;
	} solve_cfg_t;

	typedef enum logic [2:0] {
		IDLE,
		FETCH_B,
		FETCH_ROW,
		UPDATE,
		WRITE_OUT,
		DONE
	} seq_state_t;

endpackage

`default_nettype wire

// File: hdl/gs_num_pkg.sv
`default_nettype none

package gs_num_pkg;

	typedef logic signed [15:0] coef_t; // integer a_ij or b_i
	typedef logic signed [15:0] inv_t; // 1/a_ii in Q2.14
	typedef logic signed [31:0] x_t; // Q16.16
	typedef logic signed [36:0] acc_t; // 5 guard bits over x_t

	localparam x_t X_POS_MAX = 32'sh7fff_ffff;
	localparam x_t X_NEG_MAX = 32'sh8000_0000;
	localparam int INV_FRAC = 14;

	function automatic x_t sat_mul_ax(input coef_t a, input x_t x);
		logic signed [47:0] p;
		p = a * x;
		if (p[47:31] != {17{p[47]}})
			return p[47] ? X_NEG_MAX : X_POS_MAX;
		return x_t'(p[31:0]);
	endfunction

	function automatic x_t sat_to_x(input acc_t v);
		if (v[36:31] != {6{v[36]}})
			return v[36] ? X_NEG_MAX : X_POS_MAX;
		return x_t'(v[31:0]);
	endfunction

	function automatic x_t sat_mul_inv(input x_t x, input inv_t inv);
		logic signed [47:0] p;
		p = x * inv;
		p = p >>> INV_FRAC; // back to Q16.16
		if (p[47:31] != {17{p[47]}})
			return p[47] ? X_NEG_MAX : X_POS_MAX;
		return x_t'(p[31:0]);
	endfunction

endpackage

`default_nettype wire

// File: hdl/gs_regs.sv
`timescale 1ns/10ps
`default_nettype none

module gs_regs (
	input  wire logic                   i_clk,
	input  wire logic                   i_reset,
	input  wire gs_bus_pkg::wb_req_t    i_wb,
	output gs_bus_pkg::wb_rsp_t         o_wb,
	input  wire logic                   i_busy,
	input  wire logic                   i_done,
	output gs_bus_pkg::solve_cfg_t      o_cfg,
	output logic                        o_start
);

	logic        req;
	logic        ack_q;
	logic [31:0] rdat_q;
	logic [31:0] rd_data;

	assign req = i_wb.cyc && i_wb.stb && !ack_q; // one accept per strobe
	assign o_wb = '{ack: ack_q, dat: rdat_q};

	always_comb begin
		case (i_wb.adr)
			gs_bus_pkg::REG_BASE: rd_data = 32'(o_cfg.base);
			gs_bus_pkg::REG_SWEEPS: rd_data = 32'(o_cfg.sweeps);
			gs_bus_pkg::REG_STATUS: rd_data = {30'd0, i_done, i_busy};
			default: rd_data = 32'd0;
		endcase
	end

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			ack_q <= 1'b0;
			o_start <= 1'b0;
			o_cfg <= '0;
		end else begin
			ack_q <= req;
			// start pulse lost while a solve is running
			o_start <= req && i_wb.we && i_wb.adr == gs_bus_pkg::REG_CTRL &&
				i_wb.dat[0] && !i_busy && !o_start;
			if (req && i_wb.we) begin
				if (i_wb.adr == gs_bus_pkg::REG_BASE)
					o_cfg.base <= gs_bus_pkg::mem_addr_t'(i_wb.dat);
				if (i_wb.adr == gs_bus_pkg::REG_SWEEPS)
					o_cfg.sweeps <= gs_bus_pkg::sweep_t'(i_wb.dat);
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (req && !i_wb.we)
			rdat_q <= rd_data;
	end

	a_ack_follows_req: assert property (@(posedge i_clk) disable iff (i_reset)
		$rose(ack_q) |-> $past(i_wb.cyc && i_wb.stb));

endmodule

`default_nettype wire

// File: hdl/gs_row_engine.sv
`timescale 1ns/10ps
`default_nettype none

module gs_row_engine #(
	parameter int N = 16
) (
	input  wire logic                  i_clk,
	input  wire logic                  i_reset,
	input  wire logic                  i_clear,
	input  wire logic                  i_load_b,
	input  wire logic                  i_row_go,
	input  wire logic [$clog2(N)-1:0]  i_row_idx,
	input  wire logic [N*16-1:0]       i_row_word,
	input  wire logic [$clog2(N)-1:0]  i_rd_idx,
	output gs_num_pkg::x_t             o_rd_x
);

	localparam int CW = $bits(gs_num_pkg::coef_t);

	gs_num_pkg::coef_t b_q [N];
	gs_num_pkg::x_t    x_q [N];
	gs_num_pkg::acc_t  dot_sum; // sum over j != i of a_ij*x_j
	gs_num_pkg::acc_t  diff;
	gs_num_pkg::inv_t  inv_ii;
	gs_num_pkg::x_t    x_new;

	assign o_rd_x = x_q[i_rd_idx];
	assign inv_ii = gs_num_pkg::inv_t'(i_row_word[i_row_idx*CW +: CW]); // diagonal slot

	always_comb begin
		dot_sum = '0;
		for (int j = 0; j < N; j++) begin
			if (j != int'(i_row_idx))
				dot_sum = dot_sum + gs_num_pkg::acc_t'(gs_num_pkg::sat_mul_ax(
					gs_num_pkg::coef_t'(i_row_word[j*CW +: CW]), x_q[j]));
		end
		diff = (gs_num_pkg::acc_t'(b_q[i_row_idx]) <<< 16) - dot_sum;
		x_new = gs_num_pkg::sat_mul_inv(gs_num_pkg::sat_to_x(diff), inv_ii);
	end

	// x_j of earlier rows is already this sweep's value
	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			for (int j = 0; j < N; j++)
				x_q[j] <= '0;
		end else if (i_clear) begin
			for (int j = 0; j < N; j++)
				x_q[j] <= '0;
		end else if (i_row_go) begin
			x_q[i_row_idx] <= x_new;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_load_b) begin
			for (int j = 0; j < N; j++)
				b_q[j] <= gs_num_pkg::coef_t'(i_row_word[j*CW +: CW]);
		end
	end

	a_row_idx_range: assert property (@(posedge i_clk) disable iff (i_reset)
		i_row_go |-> int'(i_row_idx) < N);

endmodule

`default_nettype wire

// File: hdl/gs_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module gs_sequencer #(
	parameter int N = 16
) (
	input  wire logic                          i_clk,
	input  wire logic                          i_reset,
	input  wire gs_bus_pkg::solve_cfg_t        i_cfg,
	input  wire logic                          i_start,
	output logic                               o_busy,
	output logic                               o_done,
	output logic                               o_mem_rreq,
	output gs_bus_pkg::mem_addr_t              o_mem_addr,
	input  wire logic [N*16-1:0]               i_mem_dout,
	input  wire logic                          i_mem_dout_vld,
	output logic                               o_clear,
	output logic                               o_load_b,
	output logic                               o_row_go,
	output logic [$clog2(N)-1:0]               o_row_idx,
	output logic [N*16-1:0]                    o_row_word,
	output logic [$clog2(N)-1:0]               o_rd_idx,
	input  wire gs_num_pkg::x_t                i_rd_x,
	output logic                               o_x_wen,
	output logic [7:0]                         o_x_addr,
	output gs_num_pkg::x_t                     o_x_data
);

	localparam int IW = $clog2(N);

	gs_bus_pkg::seq_state_t state_q;
	gs_bus_pkg::solve_cfg_t cfg_q;
	gs_bus_pkg::mem_addr_t  addr_q;
	gs_bus_pkg::sweep_t     sweep_q;
	logic [IW-1:0]          idx_q; // row during sweeps, x index during write-out
	logic [N*16-1:0]        word_q;
	logic                   load_b_q;
	logic                   last_idx;

	assign last_idx = idx_q == IW'(N - 1);
	assign o_busy = state_q != gs_bus_pkg::IDLE && state_q != gs_bus_pkg::DONE;
	assign o_done = state_q == gs_bus_pkg::DONE;
	assign o_clear = i_start && !o_busy;
	assign o_mem_rreq = state_q == gs_bus_pkg::FETCH_B || state_q == gs_bus_pkg::FETCH_ROW;
	assign o_mem_addr = addr_q;
	assign o_load_b = load_b_q;
	assign o_row_go = state_q == gs_bus_pkg::UPDATE;
	assign o_row_idx = idx_q;
	assign o_row_word = word_q;
	assign o_rd_idx = idx_q;
	assign o_x_wen = state_q == gs_bus_pkg::WRITE_OUT;
	assign o_x_addr = 8'(idx_q);
	assign o_x_data = i_rd_x;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			state_q <= gs_bus_pkg::IDLE;
			cfg_q <= '0;
			addr_q <= '0;
			sweep_q <= '0;
			idx_q <= '0;
			load_b_q <= 1'b0;
		end else begin
			load_b_q <= 1'b0;
			case (state_q)
				gs_bus_pkg::IDLE, gs_bus_pkg::DONE: begin
					if (i_start) begin
						cfg_q <= i_cfg;
						addr_q <= i_cfg.base; // b word first
						sweep_q <= '0;
						idx_q <= '0;
						state_q <= gs_bus_pkg::FETCH_B;
					end
				end
				gs_bus_pkg::FETCH_B: begin
					if (i_mem_dout_vld) begin
						load_b_q <= 1'b1;
						addr_q <= cfg_q.base + 1'b1;
						if (cfg_q.sweeps == '0)
							state_q <= gs_bus_pkg::WRITE_OUT;
						else
							state_q <= gs_bus_pkg::FETCH_ROW;
					end
				end
				gs_bus_pkg::FETCH_ROW: begin
					if (i_mem_dout_vld)
						state_q <= gs_bus_pkg::UPDATE;
				end
				gs_bus_pkg::UPDATE: begin
					state_q <= gs_bus_pkg::FETCH_ROW;
					if (last_idx) begin
						idx_q <= '0;
						addr_q <= cfg_q.base + 1'b1; // back to row 0
						if (gs_bus_pkg::sweep_t'(sweep_q + 1'b1) == cfg_q.sweeps)
							state_q <= gs_bus_pkg::WRITE_OUT;
						else
							sweep_q <= sweep_q + 1'b1;
					end else begin
						idx_q <= idx_q + 1'b1;
						addr_q <= addr_q + 1'b1;
					end
				end
				gs_bus_pkg::WRITE_OUT: begin
					idx_q <= last_idx ? '0 : idx_q + 1'b1;
					if (last_idx)
						state_q <= gs_bus_pkg::DONE;
				end
				default: state_q <= gs_bus_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_mem_rreq && i_mem_dout_vld)
			word_q <= i_mem_dout;
	end

	a_mem_req_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		o_mem_rreq && !i_mem_dout_vld |=> o_mem_rreq && $stable(o_mem_addr));

endmodule

`default_nettype wire

// File: hdl/gs_solver_top.sv
`timescale 1ns/10ps
`default_nettype none

module gs_solver_top #(
	parameter int N = 16
) (
	input  wire logic                i_clk,
	input  wire logic                i_reset,
	input  wire gs_bus_pkg::wb_req_t i_wb,
	output gs_bus_pkg::wb_rsp_t      o_wb,
	output logic                     o_mem_rreq,
	output gs_bus_pkg::mem_addr_t    o_mem_addr,
	input  wire logic [N*16-1:0]     i_mem_dout,
	input  wire logic                i_mem_dout_vld,
	output logic                     o_x_wen,
	output logic [7:0]               o_x_addr,
	output gs_num_pkg::x_t           o_x_data
);

	gs_bus_pkg::solve_cfg_t cfg;
	logic                   start;
	logic                   busy;
	logic                   done;
	logic                   clear;
	logic                   load_b;
	logic                   row_go;
	logic [$clog2(N)-1:0]   row_idx;
	logic [N*16-1:0]        row_word;
	logic [$clog2(N)-1:0]   rd_idx;
	gs_num_pkg::x_t         rd_x;

	gs_regs u_regs (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_wb(i_wb),
		.o_wb(o_wb),
		.i_busy(busy),
		.i_done(done),
		.o_cfg(cfg),
		.o_start(start)
	);

	gs_sequencer #(.N(N)) u_seq (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_cfg(cfg),
		.i_start(start),
		.o_busy(busy),
		.o_done(done),
		.o_mem_rreq(o_mem_rreq),
		.o_mem_addr(o_mem_addr),
		.i_mem_dout(i_mem_dout),
		.i_mem_dout_vld(i_mem_dout_vld),
		.o_clear(clear),
		.o_load_b(load_b),
		.o_row_go(row_go),
		.o_row_idx(row_idx),
		.o_row_word(row_word),
		.o_rd_idx(rd_idx),
		.i_rd_x(rd_x),
		.o_x_wen(o_x_wen),
		.o_x_addr(o_x_addr),
		.o_x_data(o_x_data)
	);

	gs_row_engine #(.N(N)) u_row (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_clear(clear),
		.i_load_b(load_b),
		.i_row_go(row_go),
		.i_row_idx(row_idx),
		.i_row_word(row_word),
		.i_rd_idx(rd_idx),
		.o_rd_x(rd_x)
	);

endmodule

`default_nettype wire

// File: tests/gs_result_checker.sv
`timescale 1ns/10ps
`default_nettype none

module gs_result_checker #(
	parameter int N = 4
) (
	input  wire logic           i_clk,
	input  wire logic           i_reset,
	input  wire logic           i_x_wen,
	input  wire logic [7:0]     i_x_addr,
	input  wire gs_num_pkg::x_t i_x_data,
	output int                  o_errors
);

	gs_num_pkg::x_t exp_x [N];
	string          test_name = "";
	int             errors = 0;
	int             test_errs = 0;
	int             tests = 0;
	int             failed = 0;
	int             wr_count = 0;
	int             cycle = 0;
	int             last_wr = 0;

	assign o_errors = errors;

	task automatic note_failure(input string what);
		$display("%s (at %0t)", what, $time);
		test_errs++;
		errors++;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
			test_errs++;
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests++;
		if (test_errs == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			failed++;
			$display("test %s: failed with %0d errors", test_name, test_errs);
		end
	endtask

	task automatic expect_x(input int i, input gs_num_pkg::x_t v);
		exp_x[i] = v;
	endtask

	task automatic arm_writes();
		wr_count = 0;
	endtask

	task automatic check_writes();
		if (wr_count != N)
			note_failure($sformatf("saw %0d result writes instead of %0d", wr_count, N));
	endtask

	task automatic report();
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
	endtask

	// write port sampled mid-cycle
	always @(negedge i_clk) begin
		cycle++;
		if (!i_reset && i_x_wen) begin
			if (wr_count > 0 && cycle != last_wr + 1)
				note_failure("result writes are not on consecutive cycles");
			if (wr_count >= N) begin
				note_failure("more result writes than rows");
			end else begin
				check_value("o_x_addr", 32'(wr_count), 32'(i_x_addr));
				check_value($sformatf("o_x_data[%0d]", wr_count), exp_x[wr_count], i_x_data);
			end
			last_wr = cycle;
			wr_count++;
		end
	end

endmodule

`default_nettype wire

// File: tests/gs_solver_tb.sv
`timescale 1ns/10ps
`default_nettype none

module gs_solver_tb;

	localparam int N = 4;
	localparam int RECS = 3; // solve records in the stimulus file
	localparam int REC_WORDS = N + 4; // header, b, N rows, two expected words

	logic                  clk;
	logic                  reset;
	gs_bus_pkg::wb_req_t   wb_req;
	gs_bus_pkg::wb_rsp_t   wb_rsp;
	logic                  mem_rreq;
	gs_bus_pkg::mem_addr_t mem_addr;
	logic [N*16-1:0]       mem_dout;
	logic                  mem_vld;
	logic                  x_wen;
	logic [7:0]            x_addr;
	gs_num_pkg::x_t        x_data;
	int                    errors;
	integer                seed = 32'h9ad5c24b;
	logic [63:0]           stim [RECS*REC_WORDS];
	logic [N*16-1:0]       mem [1024];

	gs_solver_top #(.N(N)) u_dut (
		.i_clk(clk),
		.i_reset(reset),
		.i_wb(wb_req),
		.o_wb(wb_rsp),
		.o_mem_rreq(mem_rreq),
		.o_mem_addr(mem_addr),
		.i_mem_dout(mem_dout),
		.i_mem_dout_vld(mem_vld),
		.o_x_wen(x_wen),
		.o_x_addr(x_addr),
		.o_x_data(x_data)
	);

	gs_result_checker #(.N(N)) u_chk (
		.i_clk(clk),
		.i_reset(reset),
		.i_x_wen(x_wen),
		.i_x_addr(x_addr),
		.i_x_data(x_data),
		.o_errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory model answering after 0 to 3 cycles
	initial begin : memory_model
		int delay;
		mem_vld = 1'b0;
		mem_dout = '0;
		forever begin
			@(negedge clk);
			mem_vld = 1'b0;
			if (mem_rreq) begin
				delay = $random(seed) & 3;
				repeat (delay) @(negedge clk);
				mem_dout = mem[mem_addr];
				mem_vld = 1'b1;
			end
		end
	end

	task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] dat,
			output logic [31:0] rdat);
		int n;
		@(negedge clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!wb_rsp.ack && n < 20);
		rdat = wb_rsp.dat;
		if (!wb_rsp.ack)
			u_chk.note_failure("no wishbone ack within 20 cycles");
		wb_req = '0; // release the strobe after ack
	endtask

	task automatic load_record(input int r);
		logic [63:0] hdr;
		logic [63:0] word;
		logic [31:0] rd;
		hdr = stim[r*REC_WORDS];
		for (int w = 0; w <= N; w++)
			mem[10'(hdr[63:32]) + 10'(w)] = stim[r*REC_WORDS + 1 + w];
		for (int i = 0; i < N; i++) begin
			word = stim[r*REC_WORDS + N + 2 + i/2];
			u_chk.expect_x(i, (i % 2) ? word[63:32] : word[31:0]);
		end
		wb_access(1'b1, gs_bus_pkg::REG_BASE, hdr[63:32], rd);
		wb_access(1'b1, gs_bus_pkg::REG_SWEEPS, hdr[31:0], rd);
	endtask

	task automatic wait_done();
		logic [31:0] st;
		int polls;
		st = '0;
		polls = 0;
		while (!st[1] && polls < 100) begin
			wb_access(1'b0, gs_bus_pkg::REG_STATUS, 32'd0, st);
			polls++;
		end
		if (!st[1])
			u_chk.note_failure("solver did not report done within 100 status reads");
		else
			u_chk.check_value("STATUS", 32'h2, st);
	endtask

	task automatic run_solve(input logic poke_while_busy);
		logic [31:0] rd;
		u_chk.arm_writes();
		wb_access(1'b1, gs_bus_pkg::REG_CTRL, 32'd1, rd);
		if (poke_while_busy) begin
			wb_access(1'b0, gs_bus_pkg::REG_STATUS, 32'd0, rd);
			u_chk.check_value("STATUS", 32'h1, rd); // busy with the old done cleared
			wb_access(1'b1, gs_bus_pkg::REG_CTRL, 32'd1, rd);
		end
		wait_done();
		u_chk.check_writes();
	endtask

	initial begin : main
		logic [31:0] rd;
		wb_req = '0;
		reset = 1'b1;
		$readmemh("tests/gs_stimulus.mem", stim);
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		u_chk.begin_test("register readback");
		wb_access(1'b0, gs_bus_pkg::REG_STATUS, 32'd0, rd);
		u_chk.check_value("STATUS", 32'd0, rd);
		wb_access(1'b1, gs_bus_pkg::REG_BASE, 32'h155, rd);
		wb_access(1'b1, gs_bus_pkg::REG_SWEEPS, 32'd19, rd);
		wb_access(1'b0, gs_bus_pkg::REG_BASE, 32'd0, rd);
		u_chk.check_value("BASE", 32'h155, rd);
		wb_access(1'b0, gs_bus_pkg::REG_SWEEPS, 32'd0, rd);
		u_chk.check_value("SWEEPS", 32'd19, rd);
		u_chk.end_test();

		u_chk.begin_test("diagonal system");
		load_record(0);
		run_solve(1'b0);
		u_chk.end_test();

		u_chk.begin_test("dominant system");
		load_record(1);
		run_solve(1'b0);
		u_chk.end_test();

		u_chk.begin_test("saturation");
		load_record(2);
		run_solve(1'b0);
		u_chk.end_test();

		u_chk.begin_test("start while busy");
		load_record(1);
		run_solve(1'b1);
		u_chk.end_test();

		u_chk.begin_test("random memory latency");
		load_record(1);
		for (int k = 0; k < 4; k++)
			run_solve(1'b0);
		u_chk.end_test();

		u_chk.report();
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/gs_stimulus.mem
// 8 words per test: base (63:32) and sweeps (31:0), b word, rows 0 to 3, {x1,x0}, {x3,x2}
// coefficient j at bits 16j+15:16j, 1/a_ii in Q2.14 on the diagonal, x in Q16.16
// diagonal system, one sweep
0000001000000001
00030007FFCE0064
0000000000001000
0000000020000000
0000080000000000
4000000000000000
FFE7000000190000
000300000000E000
// tridiagonal 4/1 system, three sweeps
000002A000000003
0005000600060005
0000000000011000
0000000110000001
0001100000010000
1000000100000000
0000FDF000010280
0000FFC8000100E0
// saturation, one sweep
000003F000000001
FFFF000180007FFF
0000000000007FFF
000000007FFF0000
0000400000000000
4000000000000000
800000007FFFFFFF
FFFF000000010000
